//--- pipe_cpu.f
+incdir+hdl
hdl/cpu_pkg.sv
hdl/stage_reg.sv
hdl/decode_unit.sv
hdl/execute_unit.sv
hdl/memory_stage.sv
hdl/pipe_cpu.sv
sim/pipe_cpu_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, then judge the log

rm -f sim.log \
	&& verilator --binary --timing --assert -f pipe_cpu.f \
		--top-module pipe_cpu_tb --Mdir obj_dir -o pipe_cpu_sim \
	&& ./obj_dir/pipe_cpu_sim 2>&1 | tee sim.log \
	|| { echo "Build or simulation did not complete"; exit 1; }

grep -q "Testbench failed" sim.log && { echo "Simulation reported failure"; exit 1; }
grep -q "Testbench passed" sim.log || { echo "No result found in sim.log"; exit 1; }
exit 0

//--- sim/pipe_cpu_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_params.svh"

module pipe_cpu_tb;

	localparam logic [5:0] op_nop  = 6'd0;
	localparam logic [5:0] op_add  = 6'd1;
	localparam logic [5:0] op_sub  = 6'd2;
	localparam logic [5:0] op_and  = 6'd3;
	localparam logic [5:0] op_or   = 6'd4;
	localparam logic [5:0] op_xor  = 6'd5;
	localparam logic [5:0] op_addi = 6'd8;
	localparam logic [5:0] op_ld   = 6'd16;
	localparam logic [5:0] op_st   = 6'd17;
	localparam logic [5:0] op_undef = 6'd63;

	localparam int hold_limit  = 8;
	localparam int drain_limit = 40;

	logic                   clk;
	logic                   rst_n;
	logic                   instr_valid;
	logic [`CPU_DATA_W-1:0] instr;
	logic                   stall;
	logic                   wb_valid;
	logic [`CPU_REG_AW-1:0] wb_reg;
	logic [`CPU_DATA_W-1:0] wb_data;

	integer seed = 24;
	int     errors = 0;
	int     checks = 0;
	bit     timed_out = 1'b0;

	// Stimulus table and expected write-backs in program order
	logic [`CPU_DATA_W-1:0] tbl_instr [$];
	int                     tbl_hold [$];
	logic [`CPU_REG_AW-1:0] exp_reg_q [$];
	logic [`CPU_DATA_W-1:0] exp_data_q [$];
	logic [`CPU_REG_AW-1:0] mon_reg;
	logic [`CPU_DATA_W-1:0] mon_data;

	// Reference model state
	logic [`CPU_DATA_W-1:0] m_regs [`CPU_REG_CNT];
	logic [`CPU_DATA_W-1:0] m_mem [`CPU_DMEM_DEPTH];
	bit                     prev_load;
	logic [`CPU_REG_AW-1:0] prev_rd;

	pipe_cpu pipe_cpu_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_valid (instr_valid),
		.instr       (instr),
		.stall       (stall),
		.wb_valid    (wb_valid),
		.wb_reg      (wb_reg),
		.wb_data     (wb_data)
	);

	always #10 clk = ~clk;

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail %s: got %h, expected %h at %0t", name, got, exp, $time);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Reference model and table construction
	//////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] enc_r(input logic [5:0] op, input logic [4:0] rd,
			input logic [4:0] rs1, input logic [4:0] rs2);
		return {op, rd, rs1, rs2, 11'd0};
	endfunction

	function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rd,
			input logic [4:0] rs1, input logic [15:0] imm);
		return {op, rd, rs1, imm};
	endfunction

	// Sign bit forced so both signs show up
	task automatic rand_imm(input logic neg, output logic [15:0] imm);
		logic [31:0] r;
		r = $random(seed);
		imm = {neg, r[14:0]};
	endtask

	task automatic add_entry(input logic [31:0] ins);
		logic [5:0]              op;
		logic [4:0]              rd;
		logic [4:0]              rs1;
		logic [4:0]              src2;
		logic [31:0]             imm;
		logic [31:0]             a;
		logic [31:0]             b;
		logic [31:0]             res;
		logic [`CPU_DMEM_AW-1:0] addr;
		bit                      wr;
		bit                      use1;
		bit                      use2;
		int                      hold;
		op   = ins[31:26];
		rd   = ins[25:21];
		rs1  = ins[20:16];
		src2 = ins[15:11];
		imm  = {{16{ins[15]}}, ins[15:0]};
		wr   = 1'b0;
		use1 = 1'b0;
		use2 = 1'b0;
		res  = '0;
		case (op)
			op_add, op_sub, op_and, op_or, op_xor: begin
				use1 = 1'b1;
				use2 = 1'b1;
				wr   = 1'b1;
			end
			op_addi, op_ld: begin
				use1 = 1'b1;
				wr   = 1'b1;
			end
			op_st: begin
				use1 = 1'b1;
				use2 = 1'b1;
				src2 = rd;
			end
			default: ;
		endcase
		a    = m_regs[rs1];
		b    = m_regs[src2];
		addr = a[`CPU_DMEM_AW-1:0] + imm[`CPU_DMEM_AW-1:0];
		case (op)
			op_add:  res = a + b;
			op_sub:  res = a - b;
			op_and:  res = a & b;
			op_or:   res = a | b;
			op_xor:  res = a ^ b;
			op_addi: res = a + imm;
			op_ld:   res = m_mem[addr];
			op_st:   m_mem[addr] = b;
			default: ;
		endcase
		// A load just ahead blocks any reader of its destination for a cycle
		hold = (prev_load && ((use1 && rs1 == prev_rd) || (use2 && src2 == prev_rd))) ? 1 : 0;
		if (wr && rd != 5'd0) begin
			m_regs[rd] = res;
			exp_reg_q.push_back(rd);
			exp_data_q.push_back(res);
		end
		prev_load = (op == op_ld);
		prev_rd   = rd;
		tbl_instr.push_back(ins);
		tbl_hold.push_back(hold);
	endtask

	task automatic build_program();
		logic [15:0] imm;
		int          i;
		for (i = 1; i <= 8; i++) begin
			rand_imm(i[0], imm);
			add_entry(enc_i(op_addi, 5'(i), 5'd0, imm));
		end
		rand_imm(1'b0, imm);
		add_entry(enc_i(op_addi, 5'd9, 5'd1, imm));
		rand_imm(1'b1, imm);
		add_entry(enc_i(op_addi, 5'd9, 5'd9, imm));
		// One of each R-type
		add_entry(enc_r(op_add, 5'd10, 5'd1, 5'd2));
		add_entry(enc_r(op_sub, 5'd11, 5'd3, 5'd4));
		add_entry(enc_r(op_and, 5'd12, 5'd5, 5'd6));
		add_entry(enc_r(op_or, 5'd13, 5'd7, 5'd8));
		add_entry(enc_r(op_xor, 5'd14, 5'd1, 5'd5));
		// Dependency chain at distance 1, 2 and 3
		rand_imm(1'b0, imm);
		add_entry(enc_i(op_addi, 5'd15, 5'd0, imm));
		add_entry(enc_r(op_add, 5'd16, 5'd15, 5'd15));
		add_entry(enc_r(op_sub, 5'd17, 5'd15, 5'd16));
		add_entry(enc_r(op_xor, 5'd18, 5'd17, 5'd15));
		add_entry(enc_r(op_and, 5'd19, 5'd18, 5'd16));
		add_entry(enc_r(op_or, 5'd19, 5'd19, 5'd17));
		// Stores, loads and load-use
		add_entry(enc_i(op_addi, 5'd20, 5'd0, 16'h0040));
		add_entry(enc_i(op_st, 5'd16, 5'd20, 16'h0004));
		add_entry(enc_i(op_st, 5'd17, 5'd20, 16'hfffe));
		add_entry(enc_r(op_nop, 5'd0, 5'd0, 5'd0));
		add_entry(enc_i(op_ld, 5'd21, 5'd20, 16'h0004));
		add_entry(enc_r(op_add, 5'd22, 5'd21, 5'd1));
		add_entry(enc_i(op_ld, 5'd23, 5'd20, 16'hfffe));
		add_entry(enc_i(op_st, 5'd23, 5'd20, 16'h0008));
		add_entry(enc_i(op_ld, 5'd24, 5'd20, 16'h0008));
		add_entry(enc_r(op_nop, 5'd0, 5'd0, 5'd0));
		add_entry(enc_r(op_add, 5'd25, 5'd24, 5'd24));
		rand_imm(1'b1, imm);
		add_entry(enc_i(op_addi, 5'd26, 5'd0, imm));
		add_entry(enc_i(op_st, 5'd26, 5'd20, 16'h000c));
		add_entry(enc_i(op_ld, 5'd27, 5'd20, 16'h000c));
		add_entry(enc_r(op_sub, 5'd28, 5'd27, 5'd26));
		add_entry(enc_i(op_ld, 5'd29, 5'd20, 16'h0004));
		add_entry(enc_r(op_or, 5'd30, 5'd1, 5'd29));
		// r0 targets, undefined opcode and r0 reads
		add_entry(enc_r(op_add, 5'd0, 5'd1, 5'd2));
		rand_imm(1'b0, imm);
		add_entry(enc_i(op_addi, 5'd0, 5'd0, imm));
		add_entry(enc_r(op_undef, 5'd7, 5'd1, 5'd2));
		add_entry(enc_r(op_add, 5'd30, 5'd7, 5'd0));
		add_entry(enc_r(op_add, 5'd31, 5'd0, 5'd3));
		add_entry(enc_r(op_xor, 5'd31, 5'd0, 5'd0));
	endtask

	//////////////////////////////////////////////////////////////////////
	// Driving and monitoring
	//////////////////////////////////////////////////////////////////////

	// Holds one entry until it is accepted, counting stall cycles
	task automatic present(input int idx);
		int hold;
		instr       = tbl_instr[idx];
		instr_valid = 1'b1;
		hold        = 0;
		@(negedge clk);
		while (stall && hold < hold_limit) begin
			hold++;
			@(negedge clk);
		end
		if (stall) begin
			errors++;
			timed_out = 1'b1;
			$display("Timeout: stall stayed high for %0d cycles on entry %0d", hold, idx);
		end else begin
			check_value("stall", 32'(hold), 32'(tbl_hold[idx]));
			@(posedge clk);
			#2;
		end
	endtask

	always @(negedge clk) begin
		if (rst_n && wb_valid) begin
			if (exp_reg_q.size() == 0) begin
				errors++;
				$display("Unexpected write-back to register %0d at %0t", wb_reg, $time);
			end else begin
				mon_reg  = exp_reg_q.pop_front();
				mon_data = exp_data_q.pop_front();
				check_value("wb_reg", 32'(wb_reg), 32'(mon_reg));
				check_value("wb_data", wb_data, mon_data);
			end
		end
	end

	initial begin
		int k;
		int cnt;
		clk         = 1'b0;
		rst_n       = 1'b0;
		instr_valid = 1'b0;
		instr       = '0;
		prev_load   = 1'b0;
		prev_rd     = '0;
		for (k = 0; k < `CPU_REG_CNT; k++)
			m_regs[k] = '0;
		for (k = 0; k < `CPU_DMEM_DEPTH; k++)
			m_mem[k] = '0;
		build_program();

		for (k = 0; k < 5; k++) begin
			@(posedge clk);
			#2;
			check_value("wb_valid", 32'(wb_valid), 32'd0);
			check_value("stall", 32'(stall), 32'd0);
		end
		rst_n = 1'b1;
		for (k = 0; k < 2; k++) begin
			@(posedge clk);
			#2;
			check_value("wb_valid", 32'(wb_valid), 32'd0);
			check_value("stall", 32'(stall), 32'd0);
		end

		for (k = 0; k < tbl_instr.size() && !timed_out; k++)
			present(k);
		instr_valid = 1'b0;
		instr       = '0;

		if (!timed_out) begin
			cnt = 0;
			while (exp_reg_q.size() != 0 && cnt < drain_limit) begin
				@(posedge clk);
				cnt++;
			end
			if (exp_reg_q.size() != 0) begin
				errors++;
				$display("Timeout: %0d expected write-backs never arrived", exp_reg_q.size());
			end
			// Pipeline depth, so any stray write-back still shows up
			for (cnt = 0; cnt < 4; cnt++)
				@(posedge clk);
		end

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- hdl/pipe_cpu.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_params.svh"

module pipe_cpu (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   instr_valid,
	input  logic [`CPU_DATA_W-1:0] instr,
	output logic                   stall,
	output logic                   wb_valid,
	output logic [`CPU_REG_AW-1:0] wb_reg,
	output logic [`CPU_DATA_W-1:0] wb_data
);

	// Decode to ID/EX
	logic             id_valid;
	cpu_pkg::id_ex_t  id_d;

	// ID/EX to execute
	logic             ex_valid;
	cpu_pkg::id_ex_t  id_ex_q;
	logic             ex_load_valid;

	// Execute to memory
	logic             exm_valid;
	cpu_pkg::ex_mem_t ex_d;

	// Memory to MEM/WB, also the memory forward source
	logic             mem_valid;
	cpu_pkg::wb_t     mem_d;

	// Write-back bus
	cpu_pkg::wb_t     wb_q;

	assign ex_load_valid = ex_valid && id_ex_q.mem_read;

	//////////////////////////////////////////////////////////////////////
	// Pipeline stages, in program order
	//////////////////////////////////////////////////////////////////////

	decode_unit u_decode (
		.clk           (clk),
		.rst_n         (rst_n),
		.instr         (instr),
		.instr_valid   (instr_valid),
		.ex_load_valid (ex_load_valid),
		.ex_dest       (id_ex_q.dest),
		.wb_valid      (wb_valid),
		.wb            (wb_q),
		.stall         (stall),
		.id_valid      (id_valid),
		.id_out        (id_d)
	);

	stage_reg #(.payload_t(cpu_pkg::id_ex_t)) u_id_ex (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (id_valid),
		.in_data   (id_d),
		.out_valid (ex_valid),
		.out_data  (id_ex_q)
	);

	execute_unit u_execute (
		.ex_valid      (ex_valid),
		.id_in         (id_ex_q),
		.mem_fwd_valid (mem_valid),
		.mem_fwd       (mem_d),
		.wb_valid      (wb_valid),
		.wb            (wb_q),
		.ex_valid_out  (exm_valid),
		.ex_out        (ex_d)
	);

	memory_stage u_memory (
		.clk       (clk),
		.rst_n     (rst_n),
		.ex_valid  (exm_valid),
		.ex_in     (ex_d),
		.mem_valid (mem_valid),
		.mem_out   (mem_d)
	);

	stage_reg #(.payload_t(cpu_pkg::wb_t)) u_mem_wb (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (mem_valid),
		.in_data   (mem_d),
		.out_valid (wb_valid),
		.out_data  (wb_q)
	);

	assign wb_reg  = wb_q.dest;
	assign wb_data = wb_q.data;

endmodule

`default_nettype wire

//--- hdl/memory_stage.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_params.svh"

module memory_stage (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             ex_valid,
	input  cpu_pkg::ex_mem_t ex_in,
	output logic             mem_valid,
	output cpu_pkg::wb_t     mem_out
);

	logic [`CPU_DATA_W-1:0]  dmem [`CPU_DMEM_DEPTH];
	logic [`CPU_DMEM_AW-1:0] addr;
	logic                    q_valid;
	cpu_pkg::ex_mem_t        q;
	logic [`CPU_DATA_W-1:0]  rd_data;

	assign addr = ex_in.result[`CPU_DMEM_AW-1:0];

	//////////////////////////////////////////////////////////////////////
	// EX/MEM register and data RAM
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n)
			q_valid <= 1'b0;
		else
			q_valid <= ex_valid;
	end

	// RAM access shares the EX/MEM edge so load data lands with the load
	always_ff @(posedge clk) begin
		q <= ex_in;
		if (ex_valid && ex_in.mem_write)
			dmem[addr] <= ex_in.store_data;
		if (ex_valid && ex_in.mem_read)
			rd_data <= dmem[addr];
	end

	// Only register writes go on towards write-back
	assign mem_valid         = q_valid && q.reg_write;
	assign mem_out.reg_write = q.reg_write;
	assign mem_out.dest      = q.dest;
	assign mem_out.data      = q.mem_read ? rd_data : q.result;

	a_rw_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		q_valid |-> !(q.mem_read && q.mem_write));

endmodule

`default_nettype wire

//--- hdl/execute_unit.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_params.svh"

module execute_unit (
	input  logic             ex_valid,
	input  cpu_pkg::id_ex_t  id_in,
	input  logic             mem_fwd_valid,
	input  cpu_pkg::wb_t     mem_fwd,
	input  logic             wb_valid,
	input  cpu_pkg::wb_t     wb,
	output logic             ex_valid_out,
	output cpu_pkg::ex_mem_t ex_out
);

	logic [`CPU_DATA_W-1:0] op_a;
	logic [`CPU_DATA_W-1:0] op_b;
	logic [`CPU_DATA_W-1:0] alu_b;
	logic [`CPU_DATA_W-1:0] alu_y;
	logic                   mem_hit_a;
	logic                   mem_hit_b;
	logic                   wb_hit_a;
	logic                   wb_hit_b;

	//////////////////////////////////////////////////////////////////////
	// Forwarding
	//////////////////////////////////////////////////////////////////////

	// Memory stage holds the younger result, so it wins over write-back
	assign mem_hit_a = mem_fwd_valid && mem_fwd.reg_write && id_in.rs1_en &&
		(mem_fwd.dest == id_in.rs1);
	assign mem_hit_b = mem_fwd_valid && mem_fwd.reg_write && id_in.rs2_en &&
		(mem_fwd.dest == id_in.rs2);
	assign wb_hit_a  = wb_valid && wb.reg_write && id_in.rs1_en && (wb.dest == id_in.rs1);
	assign wb_hit_b  = wb_valid && wb.reg_write && id_in.rs2_en && (wb.dest == id_in.rs2);

	assign op_a = mem_hit_a ? mem_fwd.data : wb_hit_a ? wb.data : id_in.op1;
	assign op_b = mem_hit_b ? mem_fwd.data : wb_hit_b ? wb.data : id_in.op2;

	// Immediate covers ADDI and the load/store address
	assign alu_b = id_in.use_imm ? id_in.imm : op_b;

	//////////////////////////////////////////////////////////////////////
	// ALU
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		case (id_in.alu_op)
			cpu_pkg::ALU_ADD: alu_y = op_a + alu_b;
			cpu_pkg::ALU_SUB: alu_y = op_a - alu_b;
			cpu_pkg::ALU_AND: alu_y = op_a & alu_b;
			cpu_pkg::ALU_OR:  alu_y = op_a | alu_b;
			cpu_pkg::ALU_XOR: alu_y = op_a ^ alu_b;
			default:          alu_y = '0;
		endcase
	end

	always_comb begin
		ex_out.reg_write  = id_in.reg_write;
		ex_out.mem_read   = id_in.mem_read;
		ex_out.mem_write  = id_in.mem_write;
		ex_out.dest       = id_in.dest;
		ex_out.result     = alu_y;
		// Store data is the forwarded rd value
		ex_out.store_data = op_b;
	end

	assign ex_valid_out = ex_valid;

	// An X here means a forwarding path picked up an unwritten register
	always_comb begin
		if (ex_valid_out)
			a_result_known: assert (!$isunknown(ex_out.result));
	end

endmodule

`default_nettype wire

//--- hdl/decode_unit.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_params.svh"

module decode_unit (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic [`CPU_DATA_W-1:0] instr,
	input  logic                   instr_valid,
	input  logic                   ex_load_valid,
	input  logic [`CPU_REG_AW-1:0] ex_dest,
	input  logic                   wb_valid,
	input  cpu_pkg::wb_t           wb,
	output logic                   stall,
	output logic                   id_valid,
	output cpu_pkg::id_ex_t        id_out
);

	logic [`CPU_DATA_W-1:0] regs [`CPU_REG_CNT];
	cpu_pkg::opcode_e       opcode;
	logic [`CPU_REG_AW-1:0] rd;
	logic [`CPU_REG_AW-1:0] rs1;
	logic [`CPU_REG_AW-1:0] rs2;
	logic [15:0]            imm16;
	logic                   wb_write;

	// Instruction fields
	assign opcode = cpu_pkg::opcode_e'(instr[31:26]);
	assign rd     = instr[25:21];
	assign rs1    = instr[20:16];
	assign imm16  = instr[15:0];
	// ST reads its store data through the rd field
	assign rs2    = (opcode == cpu_pkg::OP_ST) ? rd : instr[15:11];

	//////////////////////////////////////////////////////////////////////
	// Control decode
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		id_out           = '0;
		id_out.alu_op    = cpu_pkg::ALU_ADD;
		id_out.dest      = rd;
		id_out.rs1       = rs1;
		id_out.rs2       = rs2;
		id_out.imm       = {{(`CPU_DATA_W-16){imm16[15]}}, imm16};
		case (opcode)
			cpu_pkg::OP_ADD,
			cpu_pkg::OP_SUB,
			cpu_pkg::OP_AND,
			cpu_pkg::OP_OR,
			cpu_pkg::OP_XOR: begin
				id_out.reg_write = 1'b1;
				id_out.rs1_en    = 1'b1;
				id_out.rs2_en    = 1'b1;
				case (opcode)
					cpu_pkg::OP_SUB: id_out.alu_op = cpu_pkg::ALU_SUB;
					cpu_pkg::OP_AND: id_out.alu_op = cpu_pkg::ALU_AND;
					cpu_pkg::OP_OR:  id_out.alu_op = cpu_pkg::ALU_OR;
					cpu_pkg::OP_XOR: id_out.alu_op = cpu_pkg::ALU_XOR;
					default:         id_out.alu_op = cpu_pkg::ALU_ADD;
				endcase
			end
			cpu_pkg::OP_ADDI,
			cpu_pkg::OP_LD: begin
				id_out.reg_write = 1'b1;
				id_out.use_imm   = 1'b1;
				id_out.rs1_en    = 1'b1;
				id_out.mem_read  = (opcode == cpu_pkg::OP_LD);
			end
			cpu_pkg::OP_ST: begin
				id_out.use_imm   = 1'b1;
				id_out.mem_write = 1'b1;
				id_out.rs1_en    = 1'b1;
				id_out.rs2_en    = 1'b1;
			end
			default: ;
		endcase
		// r0 is never a destination
		if (rd == '0)
			id_out.reg_write = 1'b0;
		id_out.op1 = (rs1 == '0) ? '0 : (wb_write && wb.dest == rs1) ? wb.data : regs[rs1];
		id_out.op2 = (rs2 == '0) ? '0 : (wb_write && wb.dest == rs2) ? wb.data : regs[rs2];
	end

	//////////////////////////////////////////////////////////////////////
	// Register file and load-use hazard
	//////////////////////////////////////////////////////////////////////

	assign wb_write = wb_valid && wb.reg_write && (wb.dest != '0);

	always_ff @(posedge clk) begin
		if (wb_write)
			regs[wb.dest] <= wb.data;
	end

	// Load in EX cannot forward yet, hold the consumer one cycle
	assign stall = instr_valid && ex_load_valid &&
		((id_out.rs1_en && rs1 == ex_dest) || (id_out.rs2_en && rs2 == ex_dest));
	assign id_valid = instr_valid && !stall;

	a_no_r0_write: assert property (@(posedge clk) disable iff (!rst_n)
		wb_valid && wb.reg_write |-> wb.dest != '0);

endmodule

`default_nettype wire

//--- hdl/stage_reg.sv
`timescale 1ns/10ps
`default_nettype none

module stage_reg #(
	parameter type payload_t = logic [31:0]
) (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     in_valid,
	input  payload_t in_data,
	output logic     out_valid,
	output payload_t out_data
);

	// Valid bit is the only control state here
	always_ff @(posedge clk) begin
		if (!rst_n)
			out_valid <= 1'b0;
		else
			out_valid <= in_valid;
	end

	// Payload follows every cycle, bubbles carry don't-care data
	always_ff @(posedge clk) begin
		out_data <= in_data;
	end

endmodule

`default_nettype wire

//--- hdl/cpu_pkg.sv
`default_nettype none

`include "cpu_params.svh"

package cpu_pkg;

	// Instruction kinds, anything else decodes as NOP
	typedef enum logic [5:0] {
		OP_NOP  = 6'd0,
		OP_ADD  = 6'd1,
		OP_SUB  = 6'd2,
		OP_AND  = 6'd3,
		OP_OR   = 6'd4,
		OP_XOR  = 6'd5,
		OP_ADDI = 6'd8,
		OP_LD   = 6'd16,
		OP_ST   = 6'd17
	} opcode_e;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR
	} alu_op_e;

	//////////////////////////////////////////////////////////////////////
	// Stage payloads
	//////////////////////////////////////////////////////////////////////

	// Decode to execute
	typedef struct packed {
		alu_op_e                alu_op;
		logic                   use_imm;
		logic                   reg_write;
		logic                   mem_read;
		logic                   mem_write;
		logic [`CPU_REG_AW-1:0] dest;
		logic [`CPU_REG_AW-1:0] rs1;
		logic [`CPU_REG_AW-1:0] rs2;
		logic                   rs1_en;
		logic                   rs2_en;
		logic [`CPU_DATA_W-1:0] op1;
		logic [`CPU_DATA_W-1:0] op2;
		logic [`CPU_DATA_W-1:0] imm;
	} id_ex_t;

	// Execute to memory
	typedef struct packed {
		logic                   reg_write;
		logic                   mem_read;
		logic                   mem_write;
		logic [`CPU_REG_AW-1:0] dest;
		logic [`CPU_DATA_W-1:0] result;
		logic [`CPU_DATA_W-1:0] store_data;
	} ex_mem_t;

	// Memory to write-back, also the forwarding bus
	typedef struct packed {
		logic                   reg_write;
		logic [`CPU_REG_AW-1:0] dest;
		logic [`CPU_DATA_W-1:0] data;
	} wb_t;

endpackage

`default_nettype wire

//--- hdl/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

//////////////////////////////////////////////////////////////////////
// Core widths and sizes
//////////////////////////////////////////////////////////////////////

// Data path and instruction word
`define CPU_DATA_W 32

// Register file
`define CPU_REG_AW 5
`define CPU_REG_CNT 32

// Data RAM, word addressed
`define CPU_DMEM_AW 8
`define CPU_DMEM_DEPTH 256

`endif
